/* platform_game.f */
rtl/game_pkg.sv
rtl/ctrl_pkg.sv
rtl/control_decode.sv
rtl/tile_map.sv
rtl/player_motion.sv
rtl/hazard_monitor.sv
rtl/scene_fsm.sv
rtl/platform_game.sv
test/tb_platform_game.sv

/* rtl/control_decode.sv */
module control_decode
    import ctrl_pkg::*;
(
    input  joy_t joy,
    input  key_t key,
    input  logic key_valid,
    output cmd_t cmd0,
    output cmd_t cmd1,
    output logic start_req
);

    logic key_held_left;
    logic key_held_right;
    logic key_held_jump;

    // player 0 on the joystick
    always_comb begin
        cmd0.left  = joy.x < JOY_LOW;
        cmd0.right = joy.x > JOY_HIGH;
        cmd0.jump  = joy.jump;
    end

    // player 1 follows the last key change while it stays pressed
    assign key_held_left  = key.pressed && (key.code == KEY_LEFT);
    assign key_held_right = key.pressed && (key.code == KEY_RIGHT);
    assign key_held_jump  = key.pressed && (key.code == KEY_JUMP);

    always_comb begin
        cmd1.left  = key_held_left;
        cmd1.right = key_held_right;
        cmd1.jump  = key_held_jump;
    end

    // only the press event counts, not the held level
    assign start_req = key_valid && key.pressed && (key.code == KEY_START);

endmodule

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    // keyboard scan codes
    localparam logic [8:0] KEY_START = 9'h16;
    localparam logic [8:0] KEY_LEFT  = 9'h1C;
    localparam logic [8:0] KEY_RIGHT = 9'h23;
    localparam logic [8:0] KEY_JUMP  = 9'h29;

    // joystick dead band
    localparam logic [9:0] JOY_LOW  = 10'd400;
    localparam logic [9:0] JOY_HIGH = 10'd600;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       jump;
    } joy_t;

    typedef struct packed {
        logic       pressed;
        logic [8:0] code;
    } key_t;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } cmd_t;

    typedef enum logic [1:0] {
        SCENE_START,
        SCENE_PLAY,
        SCENE_LOSE
    } scene_t;

endpackage

/* rtl/game_pkg.sv */
package game_pkg;

    // level geometry in pixels and tiles
    localparam int MAP_COLS = 20;
    localparam int MAP_ROWS = 15;

    typedef logic [3:0] tile_t;
    typedef logic [9:0] coord_t;
    typedef logic [3:0] row_t;
    typedef logic [4:0] col_t;
    typedef logic [2:0] gate_t;

    localparam coord_t TILE_SIZE = 10'd32;

    // tile codes, everything from plate 1 upwards is solid
    localparam tile_t TILE_EMPTY  = 4'h0;
    localparam tile_t TILE_SPIKE  = 4'h1;
    localparam tile_t TILE_GATE1  = 4'h2;
    localparam tile_t TILE_GATE2  = 4'h3;
    localparam tile_t TILE_GATE3  = 4'h4;
    localparam tile_t TILE_PLATE1 = 4'h5;
    localparam tile_t TILE_PLATE2 = 4'h6;
    localparam tile_t TILE_PLATE3 = 4'h7;
    localparam tile_t TILE_EXIT   = 4'h8;
    localparam tile_t TILE_WALL   = 4'h9;

    // physics, per tick
    localparam coord_t STEP_PX     = 10'd5;
    localparam coord_t JUMP_HEIGHT = 10'd64;
    localparam coord_t CEILING_Y   = 10'd10;
    localparam coord_t FLOOR_Y     = 10'd416;
    localparam coord_t X_LIMIT     = 10'd603;
    localparam coord_t FOOT_INSET  = 10'd4;

    localparam coord_t P0_START_X = 10'd32;
    localparam coord_t P0_START_Y = 10'd320;
    localparam coord_t P1_START_X = 10'd32;
    localparam coord_t P1_START_Y = 10'd416;

    // timers in ticks
    localparam int SPIKE_TICKS = 8;
    localparam logic [3:0] SPIKE_ON_PHASE = 4'd4;
    localparam int LOSE_TICKS = 40;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   face_left;
    } player_t;

    // tiles are 32 px, so the tile index is the coordinate above bit 5
    function automatic col_t px_to_col(coord_t px);
        return px[9:5];
    endfunction

    // rows never exceed 15 while y stays below 512
    function automatic row_t px_to_row(coord_t px);
        return px[8:5];
    endfunction

endpackage

/* rtl/hazard_monitor.sv */
module hazard_monitor
    import game_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  player_t p0,
    input  player_t p1,
    input  tile_t   stand0,
    input  tile_t   stand1,
    output gate_t   gates,
    output logic    spike_on,
    output logic    spike_hit
);

    logic [$clog2(SPIKE_TICKS)-1:0] tick_cnt;
    logic [3:0] phase;
    coord_t     bottom0;
    coord_t     bottom1;
    coord_t     right0;
    coord_t     right1;
    row_t       c_row [4];
    col_t       c_col [4];
    tile_t      c_tile [4];

    // gate n opens while someone's left foot is on plate n
    always_comb begin
        for (int n = 0; n < 3; n++) begin
            gates[n] = (stand0 == tile_t'(TILE_PLATE1 + n)) || (stand1 == tile_t'(TILE_PLATE1 + n));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            phase    <= '0;
        end else if (tick) begin
            if (int'(tick_cnt) == SPIKE_TICKS - 1) begin
                tick_cnt <= '0;
                phase    <= phase + 4'd1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    assign spike_on = phase > SPIKE_ON_PHASE;

    // bottom row under each body edge
    assign bottom0 = p0.y + TILE_SIZE - 10'd1;
    assign bottom1 = p1.y + TILE_SIZE - 10'd1;
    assign right0  = p0.x + TILE_SIZE - 10'd1;
    assign right1  = p1.x + TILE_SIZE - 10'd1;

    always_comb begin
        c_row[0] = px_to_row(bottom0);
        c_row[1] = px_to_row(bottom0);
        c_row[2] = px_to_row(bottom1);
        c_row[3] = px_to_row(bottom1);
        c_col[0] = px_to_col(p0.x);
        c_col[1] = px_to_col(right0);
        c_col[2] = px_to_col(p1.x);
        c_col[3] = px_to_col(right1);
    end

    tile_map u_contact_map (
        .probe_row  (c_row),
        .probe_col  (c_col),
        .probe_tile (c_tile)
    );

    assign spike_hit = spike_on && (c_tile[0] == TILE_SPIKE || c_tile[1] == TILE_SPIKE
                                 || c_tile[2] == TILE_SPIKE || c_tile[3] == TILE_SPIKE);

endmodule

/* rtl/platform_game.sv */
module platform_game
    import game_pkg::*, ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  joy_t    joy,
    input  key_t    key,
    input  logic    key_valid,
    output player_t p0,
    output player_t p1,
    output gate_t   gates,
    output logic    spike_on,
    output scene_t  scene
);

    cmd_t  cmd0;
    cmd_t  cmd1;
    logic  start_req;
    logic  spike_hit;
    tile_t stand0;
    tile_t stand1;

    control_decode u_ctrl (
        .joy       (joy),
        .key       (key),
        .key_valid (key_valid),
        .cmd0      (cmd0),
        .cmd1      (cmd1),
        .start_req (start_req)
    );

    // joystick player starts on the upper ledge
    player_motion #(
        .start_pos ('{x: P0_START_X, y: P0_START_Y, face_left: 1'b0})
    ) u_player0 (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .cmd      (cmd0),
        .gates    (gates),
        .pos      (p0),
        .standing (stand0)
    );

    player_motion #(
        .start_pos ('{x: P1_START_X, y: P1_START_Y, face_left: 1'b0})
    ) u_player1 (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .cmd      (cmd1),
        .gates    (gates),
        .pos      (p1),
        .standing (stand1)
    );

    hazard_monitor u_hazard (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .p0        (p0),
        .p1        (p1),
        .stand0    (stand0),
        .stand1    (stand1),
        .gates     (gates),
        .spike_on  (spike_on),
        .spike_hit (spike_hit)
    );

    scene_fsm u_scene (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .start_req (start_req),
        .spike_hit (spike_hit),
        .scene     (scene)
    );

endmodule

/* rtl/player_motion.sv */
module player_motion
    import game_pkg::*, ctrl_pkg::*;
#(
    parameter player_t start_pos = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  cmd_t    cmd,
    input  gate_t   gates,
    output player_t pos,
    output tile_t   standing
);

    coord_t foot_l;
    coord_t foot_r;
    coord_t below_y;
    coord_t above_y;
    coord_t mid_y;
    coord_t top_y;
    coord_t left_next;
    coord_t right_next;

    row_t  h_row [4];
    col_t  h_col [4];
    tile_t h_tile [4];
    row_t  v_row [4];
    col_t  v_col [4];
    tile_t v_tile [4];

    logic   wall_l;
    logic   wall_r;
    logic   floor_hit;
    logic   ceil_hit;
    logic   jumping;
    logic   on_ground;
    logic   start_jump;
    coord_t jump_start_y;

    // solid tiles, plus gates whose plate nobody stands on
    function automatic logic blocks(tile_t t, gate_t g);
        case (t)
            TILE_GATE1: return !g[0];
            TILE_GATE2: return !g[1];
            TILE_GATE3: return !g[2];
            default:    return t >= TILE_PLATE1;
        endcase
    endfunction

    assign foot_l     = pos.x + FOOT_INSET;
    assign foot_r     = pos.x + TILE_SIZE - FOOT_INSET - 10'd1;
    assign below_y    = pos.y + TILE_SIZE;
    assign above_y    = pos.y - 10'd1;
    assign mid_y      = pos.y + (TILE_SIZE >> 1);
    // head probe sits just inside the top edge
    assign top_y      = pos.y + FOOT_INSET;
    assign left_next  = pos.x - STEP_PX;
    assign right_next = pos.x + TILE_SIZE - 10'd1 + STEP_PX;

    // side probes: left mid, left top, right mid, right top
    always_comb begin
        h_row[0] = px_to_row(mid_y);
        h_row[1] = px_to_row(top_y);
        h_row[2] = px_to_row(mid_y);
        h_row[3] = px_to_row(top_y);
        h_col[0] = px_to_col(left_next);
        h_col[1] = px_to_col(left_next);
        h_col[2] = px_to_col(right_next);
        h_col[3] = px_to_col(right_next);
    end

    // foot probes: below left, below right, above left, above right
    always_comb begin
        v_row[0] = px_to_row(below_y);
        v_row[1] = px_to_row(below_y);
        v_row[2] = px_to_row(above_y);
        v_row[3] = px_to_row(above_y);
        v_col[0] = px_to_col(foot_l);
        v_col[1] = px_to_col(foot_r);
        v_col[2] = px_to_col(foot_l);
        v_col[3] = px_to_col(foot_r);
    end

    tile_map u_side_map (
        .probe_row  (h_row),
        .probe_col  (h_col),
        .probe_tile (h_tile)
    );

    tile_map u_foot_map (
        .probe_row  (v_row),
        .probe_col  (v_col),
        .probe_tile (v_tile)
    );

    // left screen edge counts as a wall
    assign wall_l    = (pos.x < STEP_PX) || blocks(h_tile[0], gates) || blocks(h_tile[1], gates);
    assign wall_r    = blocks(h_tile[2], gates) || blocks(h_tile[3], gates);
    assign floor_hit = blocks(v_tile[0], gates) || blocks(v_tile[1], gates);
    assign ceil_hit  = blocks(v_tile[2], gates) || blocks(v_tile[3], gates);

    assign standing   = v_tile[0];
    assign start_jump = cmd.jump && on_ground && !jumping;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos       <= start_pos;
            jumping   <= 1'b0;
            on_ground <= 1'b1;
        end else if (tick) begin
            if (cmd.left && !wall_l) begin
                pos.x         <= pos.x - STEP_PX;
                pos.face_left <= 1'b1;
            end else if (cmd.right && pos.x < X_LIMIT && !wall_r) begin
                pos.x         <= pos.x + STEP_PX;
                pos.face_left <= 1'b0;
            end

            if (jumping) begin
                if (ceil_hit || pos.y <= jump_start_y - JUMP_HEIGHT || pos.y <= CEILING_Y) begin
                    jumping <= 1'b0;
                end else begin
                    pos.y <= pos.y - STEP_PX;
                end
            end else if (floor_hit || pos.y >= FLOOR_Y) begin
                on_ground <= 1'b1;
                // snap onto the top of the tile row below
                if (pos.y >= FLOOR_Y) begin
                    pos.y <= FLOOR_Y;
                end else begin
                    pos.y <= {1'b0, v_row[0], 5'b0} - TILE_SIZE;
                end
            end else begin
                on_ground <= 1'b0;
                pos.y     <= pos.y + STEP_PX;
            end

            if (start_jump) begin
                jumping   <= 1'b1;
                on_ground <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick && start_jump) begin
            jump_start_y <= pos.y;
        end
    end

endmodule

/* rtl/scene_fsm.sv */
module scene_fsm
    import game_pkg::*, ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   tick,
    input  logic   start_req,
    input  logic   spike_hit,
    output scene_t scene
);

    scene_t next_scene;
    logic [$clog2(LOSE_TICKS)-1:0] lose_cnt;
    logic lose_done;

    // last tick of the lose scene
    assign lose_done = tick && (int'(lose_cnt) == LOSE_TICKS - 1);

    always_comb begin
        next_scene = scene;
        case (scene)
            SCENE_START: if (start_req) next_scene = SCENE_PLAY;
            SCENE_PLAY:  if (spike_hit) next_scene = SCENE_LOSE;
            SCENE_LOSE:  if (lose_done) next_scene = SCENE_START;
            default:     next_scene = SCENE_START;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scene    <= SCENE_START;
            lose_cnt <= '0;
        end else begin
            scene <= next_scene;
            // count only while losing, restart on every entry
            if (scene != SCENE_LOSE) begin
                lose_cnt <= '0;
            end else if (tick) begin
                lose_cnt <= lose_cnt + 1'b1;
            end
        end
    end

endmodule

/* rtl/tile_map.sv */
module tile_map
    import game_pkg::*;
(
    input  row_t  probe_row [4],
    input  col_t  probe_col [4],
    output tile_t probe_tile [4]
);

    typedef logic [MAP_COLS*$bits(tile_t)-1:0] map_row_t;

    // column 0 sits in the top nibble of each row
    localparam map_row_t LEVEL [MAP_ROWS] = '{
        {20{TILE_EMPTY}},
        {{10{TILE_EMPTY}}, {10{TILE_WALL}}},
        {20{TILE_EMPTY}},
        {{10{TILE_WALL}}, {10{TILE_EMPTY}}},
        {20{TILE_EMPTY}},
        {{10{TILE_WALL}}, {10{TILE_EMPTY}}},
        {20{TILE_EMPTY}},
        {{10{TILE_WALL}}, {10{TILE_EMPTY}}},
        {20{TILE_EMPTY}},
        {{7{TILE_EMPTY}}, TILE_GATE1, {4{TILE_EMPTY}}, TILE_GATE2, {4{TILE_EMPTY}},
         TILE_GATE3, TILE_EMPTY, TILE_EXIT},
        {{5{TILE_EMPTY}}, TILE_SPIKE, TILE_EMPTY, TILE_GATE1, {4{TILE_EMPTY}}, TILE_GATE2,
         {4{TILE_EMPTY}}, TILE_GATE3, TILE_EMPTY, TILE_EXIT},
        {{2{TILE_WALL}}, {3{TILE_PLATE1}}, {15{TILE_WALL}}},
        {20{TILE_EMPTY}},
        {{2{TILE_EMPTY}}, TILE_SPIKE, TILE_EMPTY, TILE_GATE1, {10{TILE_EMPTY}},
         {5{TILE_PLATE3}}},
        {{5{TILE_WALL}}, {5{TILE_PLATE1}}, {5{TILE_PLATE2}}, {5{TILE_WALL}}}
    };

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            // anything off the map reads as wall
            if (probe_row[i] >= MAP_ROWS || probe_col[i] >= MAP_COLS) begin
                probe_tile[i] = TILE_WALL;
            end else begin
                probe_tile[i] = LEVEL[probe_row[i]][(MAP_COLS - 1 - probe_col[i])
                                * $bits(tile_t) +: $bits(tile_t)];
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_platform_game -f platform_game.f -o sim_platform_game
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_platform_game > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

/* test/tb_platform_game.sv */
module tb_platform_game
    import game_pkg::*, ctrl_pkg::*;
();

    logic    clk = 1'b0;
    logic    rst;
    logic    tick = 1'b0;
    joy_t    joy;
    key_t    key;
    logic    key_valid;
    player_t p0;
    player_t p1;
    gate_t   gates;
    logic    spike_on;
    scene_t  scene;

    logic [1:0] cyc = 2'd0;
    int         tick_count;
    logic       spike_exp;
    logic       contact;
    int         seed = 32'h7bc5;
    int         exp_x;
    int         exp_y;
    int         i;
    logic       rising;

    platform_game uut (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .joy       (joy),
        .key       (key),
        .key_valid (key_valid),
        .p0        (p0),
        .p1        (p1),
        .gates     (gates),
        .spike_on  (spike_on),
        .scene     (scene)
    );

    always #5 clk = ~clk;

    // one tick strobe every 4 cycles
    always @(negedge clk) begin
        if (rst) begin
            cyc  <= 2'd0;
            tick <= 1'b0;
        end else begin
            cyc  <= cyc + 2'd1;
            tick <= (cyc == 2'd3);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_count <= 0;
        end else if (tick) begin
            tick_count <= tick_count + 1;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input int got, input int exp);
        assert (got == exp) else fail_now($sformatf("Mismatch %s: got %h expected %h",
                                                    name, got, exp));
    endtask

    // spikes of the level map: row 10 col 5 and row 13 col 2
    function automatic logic spike_at(int row, int col);
        return (row == 10 && col == 5) || (row == 13 && col == 2);
    endfunction

    function automatic logic on_spike(player_t p);
        int bottom_row;
        int left_col;
        int right_col;
        bottom_row = (int'(p.y) + 31) / 32;
        left_col   = int'(p.x) / 32;
        right_col  = (int'(p.x) + 31) / 32;
        return spike_at(bottom_row, left_col) || spike_at(bottom_row, right_col);
    endfunction

    // player 0 ledge, plate 1 covers columns 2 to 4 under the left foot
    function automatic logic on_plate1(int x);
        int col;
        col = (x + 4) / 32;
        return col >= 2 && col <= 4;
    endfunction

    // lower lane, gate 1 sits in column 4
    function automatic logic step_right_free(int x, logic gate1_open);
        return ((x + 36) / 32 != 4) || gate1_open;
    endfunction

    assign spike_exp = ((tick_count / SPIKE_TICKS) % 16) > int'(SPIKE_ON_PHASE);
    assign contact   = on_spike(p0) || on_spike(p1);

    assert property (@(posedge clk) disable iff (rst) spike_on == spike_exp)
        else fail_now($sformatf("Mismatch spike_on: got %h expected %h", spike_on, spike_exp));

    assert property (@(posedge clk) disable iff (rst)
        (scene == SCENE_PLAY && spike_on && contact) |=> scene == SCENE_LOSE)
        else fail_now("scene stayed in PLAY while a player stood on a live spike");

    // returns on the falling edge right after a tick update
    task automatic next_tick;
        int n;
        n = 0;
        @(posedge clk);
        while (!tick && n < 8) begin
            @(posedge clk);
            n++;
        end
        if (!tick) fail_now("no tick strobe seen within 8 cycles");
        @(negedge clk);
    endtask

    task automatic send_key(input logic [8:0] code, input logic pressed);
        key.pressed = pressed;
        key.code    = code;
        key_valid   = 1'b1;
        @(negedge clk);
        key_valid   = 1'b0;
    endtask

    task automatic wait_spike(input logic level, input int limit);
        int n;
        n = 0;
        while (spike_on !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (spike_on !== level) begin
            fail_now($sformatf("spike_on never reached %0d within %0d cycles", level, limit));
        end
    endtask

    initial begin
        rst       = 1'b1;
        joy       = '{x: 10'd512, y: 10'd512, jump: 1'b0};
        key       = '{pressed: 1'b0, code: 9'h0};
        key_valid = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // reset state
        check_val("p0.x", int'(p0.x), 32);
        check_val("p0.y", int'(p0.y), 320);
        check_val("p1.x", int'(p1.x), 32);
        check_val("p1.y", int'(p1.y), 416);
        check_val("p0.face_left", int'(p0.face_left), 0);
        check_val("p1.face_left", int'(p1.face_left), 0);
        check_val("scene", int'(scene), int'(SCENE_START));
        check_val("gates", int'(gates), 0);
        check_val("spike_on", int'(spike_on), 0);

        // player 1 walks right into closed gate 1, joystick noise in the dead band
        next_tick();
        send_key(KEY_RIGHT, 1'b1);
        exp_x = 32;
        for (i = 0; i < 14; i++) begin
            joy.x = 10'(400 + ($unsigned($random(seed)) % 201));
            next_tick();
            if (step_right_free(exp_x, 1'b0)) begin
                exp_x += 5;
            end
            check_val("p1.x", int'(p1.x), exp_x);
            check_val("p1.face_left", int'(p1.face_left), 0);
            check_val("p0.x", int'(p0.x), 32);
        end
        check_val("p1.x", int'(p1.x), 92);
        send_key(KEY_RIGHT, 1'b0);

        // jump arc of player 0
        joy.x    = 10'd512;
        joy.jump = 1'b1;
        exp_y    = 320;
        rising   = 1'b0;
        for (i = 0; i < 30; i++) begin
            next_tick();
            if (i == 0) begin
                rising   = 1'b1;
                joy.jump = 1'b0;
            end else if (rising) begin
                if (exp_y <= 320 - 64) begin
                    rising = 1'b0;
                end else begin
                    exp_y -= 5;
                end
            end else if (exp_y < 320) begin
                exp_y += 5;
            end
            check_val("p0.y", int'(p0.y), exp_y);
        end
        check_val("p0.y", int'(p0.y), 320);

        // player 0 onto plate 1, player 1 through the open gate
        joy.x = 10'd700;
        exp_x = 32;
        i     = 0;
        while (!on_plate1(exp_x) && i < 20) begin
            next_tick();
            exp_x += 5;
            i++;
            check_val("p0.x", int'(p0.x), exp_x);
            check_val("gates", int'(gates), int'({2'b00, on_plate1(exp_x)}));
        end
        if (!on_plate1(exp_x)) fail_now("player 0 never reached plate 1");
        joy.x = 10'd512;
        send_key(KEY_RIGHT, 1'b1);
        next_tick();
        check_val("p1.x", int'(p1.x), 97);
        send_key(KEY_RIGHT, 1'b0);
        check_val("gates", int'(gates), 1);
        joy.x = 10'd100;
        next_tick();
        check_val("p0.x", int'(p0.x), exp_x - 5);
        check_val("p0.face_left", int'(p0.face_left), 1);
        check_val("gates", int'(gates), 0);

        // park player 0 over the spike in column 5
        joy.x = 10'd700;
        exp_x = exp_x - 5;
        i     = 0;
        while (exp_x < 160 && i < 30) begin
            next_tick();
            exp_x += 5;
            i++;
            check_val("p0.x", int'(p0.x), exp_x);
            check_val("gates", int'(gates), int'({2'b00, on_plate1(exp_x)}));
        end
        joy.x = 10'd512;

        // start while the spike is safe, lose when it goes live
        wait_spike(1'b0, 1200);
        next_tick();
        send_key(KEY_START, 1'b1);
        check_val("scene", int'(scene), int'(SCENE_PLAY));
        wait_spike(1'b1, 400);
        @(negedge clk);
        check_val("scene", int'(scene), int'(SCENE_LOSE));
        for (i = 1; i <= LOSE_TICKS; i++) begin
            next_tick();
            if (i < LOSE_TICKS) begin
                check_val("scene", int'(scene), int'(SCENE_LOSE));
            end else begin
                check_val("scene", int'(scene), int'(SCENE_START));
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule
